// File: hw/serial_exec_pkg.sv
package serial_exec_pkg;

   // Data path and register file geometry
   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int BIT_CNT_W  = $clog2(XLEN);

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [XLEN-1:0]       instr_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;

   // Index of the final serial bit
   localparam bit_cnt_t LAST_BIT = bit_cnt_t'(XLEN - 1);

   // Major opcodes, instruction bits 6:2
   localparam logic [4:0] OPC_OP_IMM = 5'b00100;
   localparam logic [4:0] OPC_OP     = 5'b01100;
   localparam logic [4:0] OPC_LUI    = 5'b01101;

   // funct3 for the integer register and immediate forms
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // ALU functions seen by the serial stage
   // LUI goes through as PASS_B with operand A held at zero
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_PASS_B
   } alu_op_t;

endpackage

// File: hw/serial_stream_ifs.sv
`timescale 1ns/1ps

// Operand bits from decode to the serial ALU, one bit pair per transfer
interface operand_stream_if;
   import serial_exec_pkg::*;

   logic      valid;
   logic      ready;
   logic      op_a_bit;
   logic      op_b_bit;
   logic      last;
   alu_op_t   alu_op;
   reg_addr_t rd_addr;
   logic      rd_we;

   modport source (output valid, op_a_bit, op_b_bit, last, alu_op, rd_addr, rd_we,
                   input ready);
   modport sink   (input valid, op_a_bit, op_b_bit, last, alu_op, rd_addr, rd_we,
                   output ready);
endinterface

// Result bits from the serial ALU to the write-back collector
interface result_stream_if;
   import serial_exec_pkg::*;

   logic      valid;
   logic      ready;
   logic      res_bit;
   logic      last;
   logic      cmp_lt;
   logic      is_cmp;
   reg_addr_t rd_addr;
   logic      rd_we;

   modport source (output valid, res_bit, last, cmp_lt, is_cmp, rd_addr, rd_we,
                   input ready);
   modport sink   (input valid, res_bit, last, cmp_lt, is_cmp, rd_addr, rd_we,
                   output ready);
endinterface

// File: hw/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
   input  logic                    clk,
   input  logic                    i_rst,
   input  logic                    i_instr_valid,
   output logic                    o_instr_ready,
   input  serial_exec_pkg::instr_t i_instr,
   input  serial_exec_pkg::word_t  i_rs1_data,
   input  serial_exec_pkg::word_t  i_rs2_data,
   operand_stream_if.source        o_stream
);

   import serial_exec_pkg::*;

   typedef enum logic {
      IDLE,
      STREAM
   } state_t;

   state_t     state_q;
   bit_cnt_t   cnt_q;
   logic [4:0] opcode_q;
   logic [2:0] funct3_q;
   logic       bit30_q;
   reg_addr_t  rd_q;
   word_t      rs1_sr;
   word_t      rs2_sr;
   word_t      imm_sr;
   word_t      imm_load;
   alu_op_t    alu_op;
   logic       supported;
   logic       is_lui;
   logic       accept;
   logic       xfer;

   assign o_instr_ready = (state_q == IDLE);
   assign accept        = i_instr_valid & o_instr_ready;
   assign xfer          = o_stream.valid & o_stream.ready;

   // U layout for LUI, sign-extended I layout for everything else
   assign imm_load = (i_instr[6:2] == OPC_LUI) ? {i_instr[31:12], 12'b0}
                                                : {{20{i_instr[31]}}, i_instr[31:20]};

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (accept) begin
                  state_q <= STREAM;
                  cnt_q   <= '0;
               end
            end
            STREAM: begin
               if (xfer) begin
                  cnt_q <= cnt_q + bit_cnt_t'(1);
                  if (o_stream.last) begin
                     state_q <= IDLE;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Instruction fields and operand shifters, LSB leaves first
   always_ff @(posedge clk) begin
      if (accept) begin
         opcode_q <= i_instr[6:2];
         funct3_q <= i_instr[14:12];
         bit30_q  <= i_instr[30];
         rd_q     <= i_instr[11:7];
         rs1_sr   <= i_rs1_data;
         rs2_sr   <= i_rs2_data;
         imm_sr   <= imm_load;
      end else if (xfer) begin
         rs1_sr <= {1'b0, rs1_sr[XLEN-1:1]};
         rs2_sr <= {1'b0, rs2_sr[XLEN-1:1]};
         // Sign bit refills the top
         imm_sr <= {imm_sr[XLEN-1], imm_sr[XLEN-1:1]};
      end
   end

   always_comb begin
      alu_op    = ALU_ADD;
      supported = 1'b1;
      case (opcode_q)
         OPC_OP, OPC_OP_IMM: begin
            case (funct3_q)
               // SUB exists only in the register form
               F3_ADD:  alu_op = (opcode_q == OPC_OP && bit30_q) ? ALU_SUB : ALU_ADD;
               F3_SLT:  alu_op = ALU_SLT;
               F3_SLTU: alu_op = ALU_SLTU;
               F3_XOR:  alu_op = ALU_XOR;
               F3_OR:   alu_op = ALU_OR;
               F3_AND:  alu_op = ALU_AND;
               // Shifts are not implemented
               default: supported = 1'b0;
            endcase
         end
         OPC_LUI: alu_op = ALU_PASS_B;
         default: supported = 1'b0;
      endcase
   end

   assign is_lui = (opcode_q == OPC_LUI);

   assign o_stream.valid    = (state_q == STREAM);
   assign o_stream.op_a_bit = is_lui ? 1'b0 : rs1_sr[0];
   assign o_stream.op_b_bit = (opcode_q == OPC_OP) ? rs2_sr[0] : imm_sr[0];
   assign o_stream.last     = (cnt_q == LAST_BIT);
   assign o_stream.alu_op   = alu_op;
   assign o_stream.rd_addr  = rd_q;
   // No write for x0 or anything undecoded
   assign o_stream.rd_we    = supported & (rd_q != '0);

endmodule

// File: hw/bit_alu.sv
`timescale 1ns/1ps

module bit_alu (
   input  logic             clk,
   input  logic             i_rst,
   operand_stream_if.sink   i_ops,
   result_stream_if.source  o_res
);

   import serial_exec_pkg::*;

   logic xfer;
   logic first_q;
   logic carry_q;
   logic carry_in;
   logic is_sub;
   logic is_cmp;
   logic b_eff;
   logic sum_bit;
   logic carry_out;
   logic res_bit;
   logic cmp_lt;

   // Pure pass-through handshake, no storage in the bit path
   assign xfer        = i_ops.valid & i_ops.ready;
   assign i_ops.ready = o_res.ready;

   assign is_cmp = (i_ops.alu_op == ALU_SLT) | (i_ops.alu_op == ALU_SLTU);
   assign is_sub = (i_ops.alu_op == ALU_SUB) | is_cmp;

   // Subtract as A + ~B + 1, the +1 being the preset borrow-in
   assign b_eff     = i_ops.op_b_bit ^ is_sub;
   assign carry_in  = first_q ? is_sub : carry_q;
   assign sum_bit   = i_ops.op_a_bit ^ b_eff ^ carry_in;
   assign carry_out = (i_ops.op_a_bit & b_eff) | (i_ops.op_a_bit & carry_in) |
                      (b_eff & carry_in);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         first_q <= 1'b1;
         carry_q <= 1'b0;
      end else if (xfer) begin
         // Next transfer after bit 31 starts a new word
         first_q <= i_ops.last;
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (i_ops.alu_op)
         ALU_XOR:    res_bit = i_ops.op_a_bit ^ i_ops.op_b_bit;
         ALU_OR:     res_bit = i_ops.op_a_bit | i_ops.op_b_bit;
         ALU_AND:    res_bit = i_ops.op_a_bit & i_ops.op_b_bit;
         ALU_PASS_B: res_bit = i_ops.op_b_bit;
         default:    res_bit = sum_bit;
      endcase
   end

   // At the sign bit, differing signs decide SLT directly,
   // otherwise the difference's sign does
   always_comb begin
      case (i_ops.alu_op)
         ALU_SLT: begin
            cmp_lt = (i_ops.op_a_bit != i_ops.op_b_bit) ? i_ops.op_a_bit : sum_bit;
         end
         // No carry out of A - B means a borrow, so A < B
         ALU_SLTU: cmp_lt = ~carry_out;
         default:  cmp_lt = 1'b0;
      endcase
   end

   assign o_res.valid   = i_ops.valid;
   assign o_res.res_bit = res_bit;
   assign o_res.last    = i_ops.last;
   assign o_res.cmp_lt  = cmp_lt & i_ops.last;
   assign o_res.is_cmp  = is_cmp;
   assign o_res.rd_addr = i_ops.rd_addr;
   assign o_res.rd_we   = i_ops.rd_we;

endmodule

// File: hw/result_collect.sv
`timescale 1ns/1ps

module result_collect (
   input  logic                       clk,
   input  logic                       i_rst,
   result_stream_if.sink              i_res,
   input  logic                       i_rd_ready,
   output logic                       o_rd_valid,
   output serial_exec_pkg::reg_addr_t o_rd_addr,
   output serial_exec_pkg::word_t     o_rd_data,
   output logic                       o_rd_we
);

   import serial_exec_pkg::*;

   logic      full_q;
   logic      xfer;
   word_t     word_q;
   word_t     word_next;
   reg_addr_t rd_addr_q;
   logic      rd_we_q;

   // Stall the whole stream while a finished word waits
   assign i_res.ready = ~full_q;
   assign xfer        = i_res.valid & i_res.ready;

   // Bits enter at the top, so bit 0 lands in place after 32 shifts
   assign word_next = {i_res.res_bit, word_q[XLEN-1:1]};

   always_ff @(posedge clk) begin
      if (i_rst) begin
         full_q <= 1'b0;
      end else if (xfer && i_res.last) begin
         full_q <= 1'b1;
      end else if (full_q && i_rd_ready) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (xfer) begin
         if (i_res.last && i_res.is_cmp) begin
            word_q <= {{(XLEN-1){1'b0}}, i_res.cmp_lt};
         end else begin
            word_q <= word_next;
         end
         if (i_res.last) begin
            rd_addr_q <= i_res.rd_addr;
            rd_we_q   <= i_res.rd_we;
         end
      end
   end

   assign o_rd_valid = full_q;
   assign o_rd_addr  = rd_addr_q;
   assign o_rd_data  = word_q;
   assign o_rd_we    = rd_we_q;

endmodule

// File: hw/serial_exec_top.sv
`timescale 1ns/1ps

module serial_exec_top (
   input  logic                       clk,
   input  logic                       i_rst,
   input  logic                       i_instr_valid,
   output logic                       o_instr_ready,
   input  serial_exec_pkg::instr_t    i_instr,
   input  serial_exec_pkg::word_t     i_rs1_data,
   input  serial_exec_pkg::word_t     i_rs2_data,
   output logic                       o_rd_valid,
   input  logic                       i_rd_ready,
   output serial_exec_pkg::reg_addr_t o_rd_addr,
   output serial_exec_pkg::word_t     o_rd_data,
   output logic                       o_rd_we
);

   operand_stream_if ops_if ();
   result_stream_if  res_if ();

   // Latch instruction, serialize operands
   instr_decode u_decode (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .o_instr_ready (o_instr_ready),
      .i_instr       (i_instr),
      .i_rs1_data    (i_rs1_data),
      .i_rs2_data    (i_rs2_data),
      .o_stream      (ops_if.source)
   );

   bit_alu u_alu (
      .clk   (clk),
      .i_rst (i_rst),
      .i_ops (ops_if.sink),
      .o_res (res_if.source)
   );

   // Assemble and hold the write-back word
   result_collect u_collect (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_res      (res_if.sink),
      .i_rd_ready (i_rd_ready),
      .o_rd_valid (o_rd_valid),
      .o_rd_addr  (o_rd_addr),
      .o_rd_data  (o_rd_data),
      .o_rd_we    (o_rd_we)
   );

endmodule

// File: dv/serial_exec_properties.sv
`timescale 1ns/1ps

module serial_exec_properties (
   input logic                       clk,
   input logic                       i_rst,
   input logic                       i_instr_valid,
   input logic                       o_instr_ready,
   input logic                       o_rd_valid,
   input logic                       i_rd_ready,
   input serial_exec_pkg::reg_addr_t o_rd_addr,
   input serial_exec_pkg::word_t     o_rd_data,
   input logic                       o_rd_we
);

   // No result offered out of reset
   a_valid_low_after_reset: assert property (@(posedge clk) i_rst |=> !o_rd_valid)
      else $error("o_rd_valid high after a reset cycle");

   // A stalled result holds all of its fields
   a_result_stable: assert property (@(posedge clk) disable iff (i_rst)
      (o_rd_valid && !i_rd_ready) |=>
         (o_rd_valid && $stable(o_rd_addr) && $stable(o_rd_data) && $stable(o_rd_we)))
      else $error("Result changed while stalled by i_rd_ready");

   // Decode is busy streaming right after it takes an instruction
   a_busy_after_accept: assert property (@(posedge clk) disable iff (i_rst)
      (i_instr_valid && o_instr_ready) |=> !o_instr_ready)
      else $error("o_instr_ready high in the cycle after an acceptance");

endmodule

bind serial_exec_top serial_exec_properties u_props (
   .clk           (clk),
   .i_rst         (i_rst),
   .i_instr_valid (i_instr_valid),
   .o_instr_ready (o_instr_ready),
   .o_rd_valid    (o_rd_valid),
   .i_rd_ready    (i_rd_ready),
   .o_rd_addr     (o_rd_addr),
   .o_rd_data     (o_rd_data),
   .o_rd_we       (o_rd_we)
);

// File: dv/tb_serial_exec.sv
`timescale 1ns/1ps

module tb_serial_exec;

   import serial_exec_pkg::*;

   localparam int NUM_INSTRS   = 300;
   localparam int WAIT_LIMIT   = 400;
   localparam int QUIET_CYCLES = 40;

   logic      clk;
   logic      i_rst;
   logic      i_instr_valid;
   logic      o_instr_ready;
   instr_t    i_instr;
   word_t     i_rs1_data;
   word_t     i_rs2_data;
   logic      o_rd_valid;
   logic      i_rd_ready;
   reg_addr_t o_rd_addr;
   word_t     o_rd_data;
   logic      o_rd_we;

   // Expected results in issue order
   reg_addr_t exp_addr_q[$];
   logic      exp_we_q[$];
   word_t     exp_data_q[$];

   serial_exec_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("FAIL at %0t: %s is %h, expected %h",
                                     $time, what, got, exp));
      end
   endtask

   // RV32I semantics for the supported subset
   function automatic void model_result(input instr_t instr, input word_t rs1,
                                        input word_t rs2, output reg_addr_t rd,
                                        output logic we, output word_t data);
      logic [6:0] opcode;
      logic       ok;
      word_t      op_b;
      opcode = instr[6:0];
      rd     = instr[11:7];
      data   = '0;
      ok     = 1'b0;
      if (opcode == 7'b0110111) begin
         data = {instr[31:12], 12'h000};
         ok   = 1'b1;
      end else if (opcode == 7'b0110011 || opcode == 7'b0010011) begin
         op_b = (opcode == 7'b0110011) ? rs2 : {{20{instr[31]}}, instr[31:20]};
         ok   = 1'b1;
         case (instr[14:12])
            3'b000:  data = (opcode == 7'b0110011 && instr[30]) ? rs1 - op_b : rs1 + op_b;
            3'b010:  data = ($signed(rs1) < $signed(op_b)) ? 32'd1 : 32'd0;
            3'b011:  data = (rs1 < op_b) ? 32'd1 : 32'd0;
            3'b100:  data = rs1 ^ op_b;
            3'b110:  data = rs1 | op_b;
            3'b111:  data = rs1 & op_b;
            default: ok = 1'b0;
         endcase
      end
      we = ok && (rd != 5'd0);
   endfunction

   task automatic make_instr(output instr_t instr, output word_t rs1, output word_t rs2);
      int unsigned kind;
      logic [31:0] r;
      logic [4:0]  opc;
      kind  = $urandom_range(0, 9);
      r     = $urandom();
      instr = $urandom();
      // Roughly one in eight targets x0
      if (r[2:0] == 3'd0) instr[11:7] = 5'd0;
      case (kind)
         0, 1, 2, 3: begin
            instr[6:0]   = 7'b0110011;
            instr[31:25] = {1'b0, r[3], 5'b00000};
         end
         4, 5, 6: instr[6:0] = 7'b0010011;
         7:       instr[6:0] = 7'b0110111;
         default: begin
            opc = r[8:4];
            if (opc == 5'b00100 || opc == 5'b01100 || opc == 5'b01101) opc = 5'b11000;
            instr[6:0] = {opc, 2'b11};
         end
      endcase
      rs1 = $urandom();
      rs2 = (r[11:9] == 3'd0) ? rs1 : $urandom();
   endtask

   task automatic drive_instrs();
      instr_t    instr;
      word_t     rs1;
      word_t     rs2;
      reg_addr_t rd;
      logic      we;
      word_t     data;
      int        waited;
      for (int n = 0; n < NUM_INSTRS; n++) begin
         make_instr(instr, rs1, rs2);
         model_result(instr, rs1, rs2, rd, we, data);
         @(posedge clk);
         i_instr_valid <= 1'b1;
         i_instr       <= instr;
         i_rs1_data    <= rs1;
         i_rs2_data    <= rs2;
         waited = 0;
         @(negedge clk);
         while (!o_instr_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_with_failure("Timed out waiting for o_instr_ready");
            @(negedge clk);
         end
         // Accepted on this edge
         @(posedge clk);
         i_instr_valid <= 1'b0;
         exp_addr_q.push_back(rd);
         exp_we_q.push_back(we);
         exp_data_q.push_back(data);
      end
   endtask

   task automatic collect_results();
      int        got;
      int        waited;
      reg_addr_t exp_addr;
      logic      exp_we;
      word_t     exp_data;
      got    = 0;
      waited = 0;
      while (got < NUM_INSTRS) begin
         @(posedge clk);
         i_rd_ready <= ($urandom_range(0, 3) != 0);
         @(negedge clk);
         if (o_rd_valid && i_rd_ready) begin
            if (exp_data_q.size() == 0) stop_with_failure("Result seen with none outstanding");
            exp_addr = exp_addr_q.pop_front();
            exp_we   = exp_we_q.pop_front();
            exp_data = exp_data_q.pop_front();
            check_value("o_rd_addr", 32'(o_rd_addr), 32'(exp_addr));
            check_value("o_rd_we", 32'(o_rd_we), 32'(exp_we));
            // Data only matters when it is written back
            if (exp_we) check_value("o_rd_data", o_rd_data, exp_data);
            got++;
            waited = 0;
         end else begin
            waited++;
            if (waited > WAIT_LIMIT) stop_with_failure("Timed out waiting for a result");
         end
      end
      @(posedge clk);
      i_rd_ready <= 1'b0;
   endtask

   initial begin
      i_rst         = 1'b1;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      i_rs1_data    = '0;
      i_rs2_data    = '0;
      i_rd_ready    = 1'b0;
      void'($urandom(99));
      repeat (5) @(posedge clk);
      i_rst <= 1'b0;
      fork
         drive_instrs();
         collect_results();
      join
      // Nothing more may appear once every result is taken
      for (int i = 0; i < QUIET_CYCLES; i++) begin
         @(negedge clk);
         check_value("o_rd_valid when idle", 32'(o_rd_valid), 32'd0);
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: serial_exec_top.f
hw/serial_exec_pkg.sv
hw/serial_stream_ifs.sv
hw/instr_decode.sv
hw/bit_alu.sv
hw/result_collect.sv
hw/serial_exec_top.sv
dv/serial_exec_properties.sv
dv/tb_serial_exec.sv

// File: run.sh
#!/bin/sh
# Build the serial execute unit testbench with Verilator and run it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_serial_exec \
   -Mdir obj_dir \
   -f serial_exec_top.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_serial_exec
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

exit 0
